//--- hw/ca_shifter.sv
`timescale 1ns/1ps

module ca_shifter import hyperram_pkg::*; (
    input  logic      iClk,
    input  logic      iRstN,
    input  logic      ca_load_i,
    input  logic      ca_shift_i,
    input  op_e       op_i,
    input  mem_addr_t mem_addr_i,
    output ddr_word_t ca_word_o,
    output logic      ca_valid_o
);

    ca_t         ca_q;
    logic [1:0]  shift_idx;     // Next byte pair.
    logic [15:0] ca_pair;

    always_comb begin
        case (shift_idx)
            2'd0:    ca_pair = ca_q[47:32];
            2'd1:    ca_pair = ca_q[31:16];
            2'd2:    ca_pair = ca_q[15:0];
            default: ca_pair = '0;
        endcase
    end

    // Command word for the request.
    always_ff @(posedge iClk) begin
        if (ca_load_i) begin
            ca_q.rd_flag   <= (op_i == OP_READ_MEM);
            ca_q.reg_space <= 1'b0;
            ca_q.linear    <= 1'b1;
            ca_q.unused    <= '0;
            ca_q.row       <= mem_addr_i.row;
            ca_q.col_hi    <= mem_addr_i.col_hi;
            ca_q.reserved  <= '0;
            ca_q.col_lo    <= mem_addr_i.col_lo;
        end
        if (ca_shift_i) begin
            ca_word_o.rise <= {8'h00, ca_pair[15:8]};  // Bytes in the low half.
            ca_word_o.fall <= {8'h00, ca_pair[7:0]};
        end
    end

    always_ff @(posedge iClk or negedge iRstN) begin
        if (!iRstN) begin
            shift_idx  <= '0;
            ca_valid_o <= 1'b0;
        end else begin
            ca_valid_o <= ca_shift_i;
            if (ca_load_i) begin
                shift_idx <= '0;
            end else if (ca_shift_i) begin
                shift_idx <= shift_idx + 2'd1;
            end
        end
    end

    a_shift_count: assert property (@(posedge iClk) disable iff (!iRstN)
        ca_shift_i |-> (shift_idx < 2'(CA_WORDS)));

endmodule

//--- hw/dq_driver.sv
`timescale 1ns/1ps

module dq_driver import hyperram_pkg::*; (
    input  logic      iClk,
    input  logic      iRstN,
    input  logic      drive_en_i,
    input  ddr_word_t ca_word_i,
    input  logic      ca_valid_i,
    input  ddr_word_t beat_i,
    input  logic      beat_valid_i,
    output ddr_word_t dq_o,
    output logic      dq_oe_o
);

    ddr_word_t dq_sel;

    // Zero word while latency runs.
    always_comb begin
        if (ca_valid_i) begin
            dq_sel = ca_word_i;
        end else if (beat_valid_i) begin
            dq_sel = beat_i;
        end else begin
            dq_sel = '0;
        end
    end

    always_ff @(posedge iClk or negedge iRstN) begin
        if (!iRstN) begin
            dq_o    <= '0;
            dq_oe_o <= 1'b0;        // Bus released out of reset.
        end else begin
            dq_o    <= dq_sel;
            dq_oe_o <= drive_en_i;
        end
    end

    // CA and write data phases never overlap.
    a_one_source: assert property (@(posedge iClk) disable iff (!iRstN)
        !(ca_valid_i && beat_valid_i));

endmodule

//--- hw/hyperram_ctrl.sv
`timescale 1ns/1ps

module hyperram_ctrl import hyperram_pkg::*; #(
    parameter int RESET_LOW_CYCLES     = 500,  // tRP in clocks.
    parameter int RESET_RECOVER_CYCLES = 500,  // tRPH in clocks.
    parameter int RD_SYNC_STAGES       = 2
) (
    input  logic      iClk,
    input  logic      iRstN,

    // Host request and completion.
    input  logic      en_i,
    input  op_e       op_i,
    input  mem_addr_t mem_addr_i,
    input  burst_t    wr_data_i,
    output burst_t    rd_data_o,
    output logic      done_o,

    // Memory pins, DDR halves already split.
    output logic      ram_rst_n_o,
    output logic      ram_cs_n_o,
    output ddr_word_t dq_o,
    output logic      dq_oe_o,
    input  ddr_word_t dq_i,
    input  logic      rwds_i
);

    logic      ca_load;     // Latch request into CA register.
    logic      ca_shift;
    logic      wr_beat_en;
    logic      drive_en;
    logic      rd_window;   // Read beats expected on dq_i.
    logic      beats_done;
    ddr_word_t ca_word;
    logic      ca_valid;
    ddr_word_t beat;
    logic      beat_valid;

    ////////////////////////////////////////
    // Control.
    ////////////////////////////////////////
    hyperram_sequencer #(
        .RESET_LOW_CYCLES     (RESET_LOW_CYCLES),
        .RESET_RECOVER_CYCLES (RESET_RECOVER_CYCLES)
    ) hyperram_sequencer_inst (
        .iClk         (iClk),
        .iRstN        (iRstN),
        .en_i         (en_i),
        .op_i         (op_i),
        .rwds_i       (rwds_i),
        .beats_done_i (beats_done),
        .ca_load_o    (ca_load),
        .ca_shift_o   (ca_shift),
        .wr_beat_en_o (wr_beat_en),
        .drive_en_o   (drive_en),
        .rd_window_o  (rd_window),
        .ram_rst_n_o  (ram_rst_n_o),
        .ram_cs_n_o   (ram_cs_n_o),
        .done_o       (done_o)
    );

    ////////////////////////////////////////
    // Transmit path.
    ////////////////////////////////////////
    ca_shifter ca_shifter_inst (
        .iClk       (iClk),
        .iRstN      (iRstN),
        .ca_load_i  (ca_load),
        .ca_shift_i (ca_shift),
        .op_i       (op_i),
        .mem_addr_i (mem_addr_i),
        .ca_word_o  (ca_word),
        .ca_valid_o (ca_valid)
    );

    wr_beat_serializer wr_beat_serializer_inst (
        .iClk         (iClk),
        .iRstN        (iRstN),
        .wr_beat_en_i (wr_beat_en),
        .wr_data_i    (wr_data_i),
        .beat_o       (beat),
        .beat_valid_o (beat_valid)
    );

    dq_driver dq_driver_inst (
        .iClk         (iClk),
        .iRstN        (iRstN),
        .drive_en_i   (drive_en),
        .ca_word_i    (ca_word),
        .ca_valid_i   (ca_valid),
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .dq_o         (dq_o),
        .dq_oe_o      (dq_oe_o)
    );

    ////////////////////////////////////////
    // Receive path.
    ////////////////////////////////////////
    rd_capture #(
        .RD_SYNC_STAGES (RD_SYNC_STAGES)
    ) rd_capture_inst (
        .iClk         (iClk),
        .iRstN        (iRstN),
        .rd_window_i  (rd_window),
        .dq_i         (dq_i),
        .rd_data_o    (rd_data_o),
        .beats_done_o (beats_done)
    );

endmodule

//--- hw/hyperram_pkg.sv
package hyperram_pkg;

    ////////////////////////////////////////
    // Protocol constants.
    ////////////////////////////////////////
    localparam int CA_WORDS       = 3;  // Bus cycles per command-address word.
    localparam int BURST_BEATS    = 4;  // Data cycles per linear burst.
    localparam int LATENCY_BASE   = 4;  // One latency count.
    localparam int LATENCY_DOUBLE = 8;  // RWDS high during CA, two counts.

    // Host operation request.
    typedef enum logic [2:0] {
        OP_RESET     = 3'b000,  // Hardware reset pulse.
        OP_READ_MEM  = 3'b011,  // Linear burst read.
        OP_WRITE_MEM = 3'b100,  // Linear burst write.
        OP_IDLE      = 3'b111
    } op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RST_LOW,             // Reset pin held low.
        ST_RST_RECOVER,         // Wait before the first access.
        ST_CA,                  // Command-address issue.
        ST_LATENCY,             // Initial access latency.
        ST_WR_DATA,             // Write beats plus pipeline drain.
        ST_RD_DATA,             // Read window, then wait for capture.
        ST_DONE
    } seq_state_e;

    ////////////////////////////////////////
    // Address and bus formats.
    ////////////////////////////////////////
    typedef struct packed {
        logic [14:0] row;
        logic [4:0]  col_hi;
        logic [2:0]  col_lo;
    } mem_addr_t;

    // Command-address word, bit 47 first on the bus.
    typedef struct packed {
        logic        rd_flag;   // 1 = read transaction.
        logic        reg_space; // Always memory space.
        logic        linear;    // Always linear burst.
        logic [8:0]  unused;
        logic [14:0] row;
        logic [4:0]  col_hi;
        logic [12:0] reserved;
        logic [2:0]  col_lo;
    } ca_t;

    // One bus cycle, both clock edges.
    typedef struct packed {
        logic [15:0] rise;
        logic [15:0] fall;
    } ddr_word_t;

    // Beat 0 sits in bits 31 to 0.
    typedef ddr_word_t [BURST_BEATS-1:0] burst_t;

endpackage

//--- hw/hyperram_sequencer.sv
`timescale 1ns/1ps

module hyperram_sequencer import hyperram_pkg::*; #(
    parameter int RESET_LOW_CYCLES     = 500,
    parameter int RESET_RECOVER_CYCLES = 500
) (
    input  logic iClk,
    input  logic iRstN,
    input  logic en_i,
    input  op_e  op_i,
    input  logic rwds_i,
    input  logic beats_done_i,
    output logic ca_load_o,
    output logic ca_shift_o,
    output logic wr_beat_en_o,
    output logic drive_en_o,
    output logic rd_window_o,
    output logic ram_rst_n_o,
    output logic ram_cs_n_o,
    output logic done_o
);

    // The FSM issues two clocks ahead of the pins. Shifter or serializer
    // adds one stage and the DQ register one more.
    localparam logic [15:0] RST_LOW_LAST  = 16'(RESET_LOW_CYCLES - 1);
    localparam logic [15:0] RST_REC_LAST  = 16'(RESET_RECOVER_CYCLES - 1);
    localparam logic [15:0] CA_LAST       = 16'(CA_WORDS - 1);
    localparam logic [15:0] LAT_BASE_LAST = 16'(LATENCY_BASE - 1);
    localparam logic [15:0] LAT_DBL_LAST  = 16'(LATENCY_DOUBLE - 1);
    localparam logic [15:0] BEATS         = 16'(BURST_BEATS);

    typedef struct packed {
        logic cs;   // Chip select active.
        logic ca;   // Command-address word on the bus.
        logic rdw;  // Read beat expected on the bus.
    } bus_ctl_t;

    seq_state_e     state_q;
    seq_state_e     state_d;
    logic [15:0]    cnt_q;
    logic [15:0]    cnt_d;
    logic [15:0]    lat_last;
    logic           lat_double_q;   // Any RWDS high seen during CA.
    logic           data_issue;
    logic           issue_oe;
    bus_ctl_t       issue;
    bus_ctl_t [1:0] pipe_q;         // Issue to pin alignment.
    logic           oe_q;

    assign lat_last   = lat_double_q ? LAT_DBL_LAST : LAT_BASE_LAST;
    assign data_issue = (state_q == ST_WR_DATA || state_q == ST_RD_DATA) && (cnt_q < BEATS);

    assign issue.cs  = (state_q == ST_CA) || (state_q == ST_LATENCY) || data_issue;
    assign issue.ca  = (state_q == ST_CA);
    assign issue.rdw = data_issue && (state_q == ST_RD_DATA);
    // Reads release DQ right after the command-address cycles.
    assign issue_oe  = issue.ca || (issue.cs && op_i == OP_WRITE_MEM);

    assign ca_load_o    = (state_q == ST_IDLE) && en_i &&
                          (op_i == OP_READ_MEM || op_i == OP_WRITE_MEM);
    assign ca_shift_o   = (state_q == ST_CA);
    assign wr_beat_en_o = data_issue && (state_q == ST_WR_DATA);
    assign drive_en_o   = oe_q;             // DQ driver adds the last stage.
    assign rd_window_o  = pipe_q[1].rdw;
    assign ram_cs_n_o   = !pipe_q[1].cs;
    assign ram_rst_n_o  = (state_q != ST_RST_LOW);
    assign done_o       = (state_q == ST_DONE);

    ////////////////////////////////////////
    // Next state.
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q + 16'd1;
        case (state_q)
            ST_IDLE: begin
                cnt_d = '0;
                if (en_i) begin
                    case (op_i)
                        OP_RESET:                 state_d = ST_RST_LOW;
                        OP_READ_MEM, OP_WRITE_MEM: state_d = ST_CA;
                        default:                  state_d = ST_IDLE;
                    endcase
                end
            end
            ST_RST_LOW: if (cnt_q == RST_LOW_LAST) begin
                state_d = ST_RST_RECOVER;
                cnt_d   = '0;
            end
            ST_RST_RECOVER: if (cnt_q == RST_REC_LAST) begin
                state_d = ST_DONE;
            end
            ST_CA: if (cnt_q == CA_LAST) begin
                state_d = ST_LATENCY;
                cnt_d   = '0;
            end
            ST_LATENCY: if (cnt_q == lat_last) begin
                state_d = (op_i == OP_WRITE_MEM) ? ST_WR_DATA : ST_RD_DATA;
                cnt_d   = '0;
            end
            // Two extra clocks let the last beat leave the pins.
            ST_WR_DATA: if (cnt_q == BEATS + 16'd1) begin
                state_d = ST_DONE;
            end
            ST_RD_DATA: begin
                if (cnt_q == BEATS) begin
                    cnt_d = cnt_q;          // Hold until capture finishes.
                end
                if (beats_done_i) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
        // Host withdrew the request.
        if (!en_i) begin
            state_d = ST_IDLE;
            cnt_d   = '0;
        end
    end

    always_ff @(posedge iClk or negedge iRstN) begin
        if (!iRstN) begin
            state_q      <= ST_IDLE;
            cnt_q        <= '0;
            pipe_q       <= '0;
            oe_q         <= 1'b0;
            lat_double_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            if (en_i) begin
                pipe_q <= {pipe_q[0], issue};
                oe_q   <= issue_oe;
            end else begin
                pipe_q <= '0;                // Abort frees the bus at once.
                oe_q   <= 1'b0;
            end
            if (ca_load_o) begin
                lat_double_q <= 1'b0;
            end else if (pipe_q[1].ca && rwds_i) begin
                lat_double_q <= 1'b1;        // Sampled on the pins, not at issue.
            end
        end
    end

    // Chip select back high by the time the FSM idles.
    a_cs_idle: assert property (@(posedge iClk) disable iff (!iRstN)
        state_q == ST_IDLE |-> ram_cs_n_o);

    a_done_pulse: assert property (@(posedge iClk) disable iff (!iRstN)
        done_o |=> !done_o);

endmodule

//--- hw/rd_capture.sv
`timescale 1ns/1ps

module rd_capture import hyperram_pkg::*; #(
    parameter int RD_SYNC_STAGES = 2
) (
    input  logic      iClk,
    input  logic      iRstN,
    input  logic      rd_window_i,
    input  ddr_word_t dq_i,
    output burst_t    rd_data_o,
    output logic      beats_done_o
);

    localparam int LAST = RD_SYNC_STAGES - 1;

    ddr_word_t                      dq_sync [RD_SYNC_STAGES];
    logic [RD_SYNC_STAGES-1:0]      win_sync;   // Window follows its data.
    logic [$clog2(BURST_BEATS)-1:0] beat_idx;

    ////////////////////////////////////////
    // Sync stages.
    ////////////////////////////////////////
    always_ff @(posedge iClk) begin
        dq_sync[0] <= dq_i;
        for (int i = 1; i < RD_SYNC_STAGES; i++) begin
            dq_sync[i] <= dq_sync[i-1];
        end
    end

    always_ff @(posedge iClk or negedge iRstN) begin
        if (!iRstN) begin
            win_sync <= '0;
        end else begin
            win_sync <= RD_SYNC_STAGES'({win_sync, rd_window_i});  // Upper bit drops off.
        end
    end

    ////////////////////////////////////////
    // Beat assembly.
    ////////////////////////////////////////
    always_ff @(posedge iClk) begin
        if (win_sync[LAST]) begin
            rd_data_o[beat_idx] <= dq_sync[LAST];
        end
    end

    always_ff @(posedge iClk or negedge iRstN) begin
        if (!iRstN) begin
            beat_idx     <= '0;
            beats_done_o <= 1'b0;
        end else begin
            beats_done_o <= win_sync[LAST] && (beat_idx == $bits(beat_idx)'(BURST_BEATS - 1));
            if (win_sync[LAST]) begin
                beat_idx <= beat_idx + 1'b1;
            end else begin
                beat_idx <= '0;     // Window gap starts a new burst.
            end
        end
    end

endmodule

//--- hw/wr_beat_serializer.sv
`timescale 1ns/1ps

module wr_beat_serializer import hyperram_pkg::*; (
    input  logic      iClk,
    input  logic      iRstN,
    input  logic      wr_beat_en_i,
    input  burst_t    wr_data_i,
    output ddr_word_t beat_o,
    output logic      beat_valid_o
);

    logic [$clog2(BURST_BEATS)-1:0] beat_idx;

    always_ff @(posedge iClk) begin
        if (wr_beat_en_i) begin
            beat_o <= wr_data_i[beat_idx];  // Beat 0 first.
        end
    end

    always_ff @(posedge iClk or negedge iRstN) begin
        if (!iRstN) begin
            beat_idx     <= '0;
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= wr_beat_en_i;
            // Index restarts between bursts.
            if (wr_beat_en_i) begin
                beat_idx <= beat_idx + 1'b1;
            end else begin
                beat_idx <= '0;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hyperram_ctrl \
    -f verilog.f -o sim_hyperram > build.log 2>&1 \
    && ./obj_dir/sim_hyperram > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/hyperram_model.sv
`timescale 1ns/1ps

module hyperram_model import hyperram_pkg::*; (
    input  logic      iClk,
    input  logic      ram_rst_n_i,
    input  logic      ram_cs_n_i,
    input  ddr_word_t dq_i,         // Bus word from the controller.
    input  logic      dq_oe_i,
    output ddr_word_t dq_o,         // Read beats back to the controller.
    output logic      rwds_o
);

    integer              seed = 3;
    burst_t              mem [logic [22:0]];  // Stored bursts by address.
    ca_t                 ca_cur;
    ddr_word_t           words [$];           // Every bus word of this transaction.
    burst_t              wr_burst;
    burst_t              rd_burst;
    int                  idx = 0;              // Chip-select-low cycle number.
    int                  lat;
    int                  start;
    int                  oe_err;
    int                  rst_cnt = 0;

    // Results of the last finished transaction, read by the testbench.
    ca_t                 last_ca;
    ddr_word_t           last_words [$];
    logic                last_rwds;
    int                  last_oe_err;
    int                  rst_low_len = 0;

    initial begin
        dq_o   = '0;
        rwds_o = 1'b0;
    end

    ////////////////////////////////////////
    // Reset pulse length.
    ////////////////////////////////////////
    always @(posedge iClk) begin
        if (!ram_rst_n_i) begin
            rst_cnt = rst_cnt + 1;
        end else if (rst_cnt > 0) begin
            rst_low_len = rst_cnt;             // Pulse just ended.
            rst_cnt     = 0;
        end
    end

    ////////////////////////////////////////
    // Bus transactions.
    ////////////////////////////////////////
    always @(posedge iClk) begin
        if (!ram_cs_n_i) begin
            words.push_back(dq_i);
            if (idx == 0) begin
                lat    = rwds_o ? LATENCY_DOUBLE : LATENCY_BASE;
                start  = CA_WORDS + lat;        // First data cycle.
                oe_err = 0;
            end
            if (idx < CA_WORDS) begin
                // Two CA bytes per cycle, high byte on the rising half.
                ca_cur = ca_t'({ca_cur[31:0], dq_i.rise[7:0], dq_i.fall[7:0]});
                if (!dq_oe_i) oe_err = oe_err + 1;
            end else if (ca_cur.rd_flag && dq_oe_i) begin
                oe_err = oe_err + 1;            // Reads leave DQ to the memory.
            end else if (!ca_cur.rd_flag && !dq_oe_i) begin
                oe_err = oe_err + 1;
            end
            if (idx == CA_WORDS - 1) begin
                if (mem.exists({ca_cur.row, ca_cur.col_hi, ca_cur.col_lo})) begin
                    rd_burst = mem[{ca_cur.row, ca_cur.col_hi, ca_cur.col_lo}];
                end else begin
                    rd_burst = '0;              // Never written.
                end
            end
            // Write beats, stored once the burst is complete.
            if (!ca_cur.rd_flag && idx >= start && idx < start + BURST_BEATS) begin
                wr_burst[idx - start] = dq_i;
                if (idx == start + BURST_BEATS - 1) begin
                    mem[{ca_cur.row, ca_cur.col_hi, ca_cur.col_lo}] = wr_burst;
                end
            end
            // Drive the read beat for the coming cycle.
            if (idx >= CA_WORDS && ca_cur.rd_flag &&
                idx + 1 >= start && idx + 1 < start + BURST_BEATS) begin
                dq_o <= rd_burst[idx + 1 - start];
            end else begin
                dq_o <= '0;
            end
            idx = idx + 1;
        end else begin
            if (idx > 0) begin
                last_ca     = ca_cur;
                last_words  = words;
                last_rwds   = rwds_o;
                last_oe_err = oe_err;
            end
            words.delete();
            idx    = 0;
            dq_o   <= '0;
            rwds_o <= 1'($random(seed));        // New level for the next transaction.
        end
    end

endmodule

//--- verification/tb_hyperram_ctrl.sv
`timescale 1ns/1ps

module tb_hyperram_ctrl import hyperram_pkg::*; ();

    localparam int RESET_LOW_CYCLES     = 20;
    localparam int RESET_RECOVER_CYCLES = 20;
    localparam int NUM_OPS              = 40;
    localparam int CYCLES_PER_OP        = 60;
    localparam int TIMEOUT              = NUM_OPS * CYCLES_PER_OP + 8;

    logic      iClk;
    logic      iRstN;
    logic      en_i;
    op_e       op_i;
    mem_addr_t mem_addr_i;
    burst_t    wr_data_i;
    burst_t    rd_data_o;
    logic      done_o;
    logic      ram_rst_n_o;
    logic      ram_cs_n_o;
    ddr_word_t dq_o;
    logic      dq_oe_o;
    ddr_word_t dq_i;
    logic      rwds_i;

    integer    seed = 3;
    int        cycle_cnt = 0;
    mem_addr_t addr_pool [8];               // Small pool so reads hit writes.
    burst_t    ref_mem [logic [22:0]];

    hyperram_ctrl #(
        .RESET_LOW_CYCLES     (RESET_LOW_CYCLES),
        .RESET_RECOVER_CYCLES (RESET_RECOVER_CYCLES)
    ) hyperram_ctrl_inst (
        .iClk (iClk), .iRstN (iRstN), .en_i (en_i), .op_i (op_i),
        .mem_addr_i (mem_addr_i), .wr_data_i (wr_data_i), .rd_data_o (rd_data_o),
        .done_o (done_o), .ram_rst_n_o (ram_rst_n_o), .ram_cs_n_o (ram_cs_n_o),
        .dq_o (dq_o), .dq_oe_o (dq_oe_o), .dq_i (dq_i), .rwds_i (rwds_i)
    );

    hyperram_model model_inst (
        .iClk (iClk), .ram_rst_n_i (ram_rst_n_o), .ram_cs_n_i (ram_cs_n_o),
        .dq_i (dq_o), .dq_oe_i (dq_oe_o), .dq_o (dq_i), .rwds_o (rwds_i)
    );

    initial begin
        iClk = 1'b0;
        forever #5 iClk = ~iClk;
    end

    always @(posedge iClk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Compare tasks.
    ////////////////////////////////////////
    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_burst(string what, burst_t exp, burst_t got);
        if (got !== exp) begin
            $display("FAIL @%0t: %s expected %h got %h", $time, what, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_ca(ca_t exp, ca_t got);
        if (got !== exp) begin
            $display("FAIL @%0t: CA word expected %h got %h", $time, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_cycles(string what, int exp, int got);
        if (got != exp) begin
            $display("FAIL @%0t: %s expected %0d got %0d", $time, what, exp, got);
            stop_on_error();
        end
    endtask

    // CA word by the field rule of the bus.
    function automatic ca_t expect_ca(op_e op, mem_addr_t a);
        ca_t c;
        c         = '0;
        c.rd_flag = (op == OP_READ_MEM);
        c.linear  = 1'b1;
        c.row     = a.row;
        c.col_hi  = a.col_hi;
        c.col_lo  = a.col_lo;
        return c;
    endfunction

    ////////////////////////////////////////
    // Host operations.
    ////////////////////////////////////////
    task automatic request(op_e op, mem_addr_t a, burst_t d);
        @(posedge iClk);
        en_i       <= 1'b1;
        op_i       <= op;
        mem_addr_i <= a;
        wr_data_i  <= d;
    endtask

    // Waits for done_o, tracks the reset pin, then releases the request.
    task automatic finish_op(output int low, output int rec);
        low = 0;
        rec = 0;
        forever begin
            @(posedge iClk);
            if (done_o) break;
            if (!ram_rst_n_o) low = low + 1;
            else if (low > 0) rec = rec + 1;   // Recovery after the pulse.
        end
        check_cycles("chip select high at done", 1, int'(ram_cs_n_o));
        en_i <= 1'b0;
        op_i <= OP_IDLE;
        @(posedge iClk);
        check_cycles("done_o pulse width", 1, 1 + int'(done_o));
        #1;
    endtask

    task automatic pulse_ram_reset();
        int low;
        int rec;
        request(OP_RESET, '0, '0);
        finish_op(low, rec);
        check_cycles("reset low cycles", RESET_LOW_CYCLES, low);
        check_cycles("reset recovery cycles", RESET_RECOVER_CYCLES, rec);
        check_cycles("model reset pulse", RESET_LOW_CYCLES, model_inst.rst_low_len);
    endtask

    task automatic write_burst(mem_addr_t a, burst_t d);
        int     low;
        int     rec;
        int     lat;
        int     first;
        burst_t seen;
        request(OP_WRITE_MEM, a, d);
        finish_op(low, rec);
        check_ca(expect_ca(OP_WRITE_MEM, a), model_inst.last_ca);
        lat = model_inst.last_rwds ? LATENCY_DOUBLE : LATENCY_BASE;
        check_cycles("write bus cycles", CA_WORDS + lat + BURST_BEATS,
                     model_inst.last_words.size());
        first = CA_WORDS;
        while (first < model_inst.last_words.size() && model_inst.last_words[first] == '0)
            first = first + 1;                  // Latency words are zero.
        check_cycles("first beat after CA", lat, first - CA_WORDS);
        for (int k = 0; k < BURST_BEATS; k++) seen[k] = model_inst.last_words[first + k];
        check_burst("write beats", d, seen);
        check_cycles("dq_oe errors", 0, model_inst.last_oe_err);
        ref_mem[a] = d;
    endtask

    task automatic read_burst(mem_addr_t a);
        int     low;
        int     rec;
        burst_t exp;
        request(OP_READ_MEM, a, '0);
        finish_op(low, rec);
        check_ca(expect_ca(OP_READ_MEM, a), model_inst.last_ca);
        exp = ref_mem.exists(a) ? ref_mem[a] : '0;
        check_burst("read data", exp, rd_data_o);
        check_cycles("dq_oe errors", 0, model_inst.last_oe_err);
    endtask

    // Drops en_i part way through; no done_o and chip select back high.
    task automatic abort_midway(op_e op, mem_addr_t a, burst_t d);
        int wait_cycles;
        wait_cycles = 2 + ($random(seed) & 3);
        request(op, a, d);
        repeat (wait_cycles) begin
            @(posedge iClk);
            check_cycles("done_o before abort", 0, int'(done_o));
        end
        en_i <= 1'b0;
        op_i <= OP_IDLE;
        for (int k = 0; k < 10; k++) begin
            @(posedge iClk);
            check_cycles("done_o after abort", 0, int'(done_o));
            if (k > 0) check_cycles("chip select after abort", 1, int'(ram_cs_n_o));
        end
    endtask

    ////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////
    initial begin
        int     sel;
        burst_t d;
        en_i       = 1'b0;
        op_i       = OP_IDLE;
        mem_addr_i = '0;
        wr_data_i  = '0;
        iRstN      = 1'b0;
        for (int k = 0; k < 8; k++) addr_pool[k] = mem_addr_t'($random(seed));
        repeat (8) @(posedge iClk);
        iRstN <= 1'b1;
        @(posedge iClk);
        check_cycles("chip select after reset", 1, int'(ram_cs_n_o));
        check_cycles("reset pin after reset", 1, int'(ram_rst_n_o));
        check_cycles("dq_oe after reset", 0, int'(dq_oe_o));
        check_cycles("done_o after reset", 0, int'(done_o));
        pulse_ram_reset();
        for (int n = 1; n < NUM_OPS; n++) begin
            sel = $random(seed) & 7;
            for (int k = 0; k < BURST_BEATS; k++) d[k] = ddr_word_t'($random(seed));
            d[0].fall[0] = 1'b1;                // Beat 0 never zero.
            case (sel)
                0:       pulse_ram_reset();
                1:       abort_midway(((n & 1) != 0) ? OP_WRITE_MEM : OP_READ_MEM,
                                      addr_pool[$random(seed) & 7], d);
                2, 3, 4: write_burst(addr_pool[$random(seed) & 7], d);
                default: read_burst(addr_pool[$random(seed) & 7]);
            endcase
            check_cycles("chip select between operations", 1, int'(ram_cs_n_o));
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog.f
hw/hyperram_pkg.sv
hw/hyperram_sequencer.sv
hw/ca_shifter.sv
hw/wr_beat_serializer.sv
hw/dq_driver.sv
hw/rd_capture.sv
hw/hyperram_ctrl.sv
verification/hyperram_model.sv
verification/tb_hyperram_ctrl.sv
